//--- design/sdramDevicePkg.sv
package sdramDevicePkg;

	//////////////////////////////////////////////////////////////////////
	// SDRAM command word, 13-bit row, 4 banks, x16
	//////////////////////////////////////////////////////////////////////

	// command bits from msb: clock enable, chip select, RAS, CAS, WE
	// chip select and the three strobes are active low
	typedef enum logic [4:0] {
		cmdPowerUp      = 5'b00000,	// cke and cs low while the device powers up
		cmdNop          = 5'b10111,	// selected, no strobes
		cmdPrechargeAll = 5'b10010,	// ras + we, needs A10 high
		cmdAutoRefresh  = 5'b10001,	// ras + cas
		cmdModeRegSet   = 5'b10000	// all three strobes, opcode on the address lines
	} sdramCmdT;

	//////////////////////////////////////////////////////////////////////
	// address and bank lines
	//////////////////////////////////////////////////////////////////////

	localparam int sdramAddrW = 13;	// row address A12..A0
	localparam int sdramBankW = 2;	// BA1..BA0

	localparam int a10Bit = 10;	// high selects all banks on a precharge

	//////////////////////////////////////////////////////////////////////
	// mode register
	//////////////////////////////////////////////////////////////////////

	// A2..A0   burst length, 000 gives a single word
	// A3       burst type, sequential
	// A6..A4   CAS latency, 010 gives two clocks
	// A9       write burst mode, single location access
	localparam logic [sdramAddrW-1:0] modeRegWord = 13'h220;

	// bank address while loading the mode register
	localparam logic [sdramBankW-1:0] modeRegBank = '0;

endpackage

//--- design/sdramCtrlPkg.sv
package sdramCtrlPkg;

	//////////////////////////////////////////////////////////////////////
	// controller states, init sequence first, then the periodic loop
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		stInit,			// load the power-up timer
		stPowerWait,		// hold cke/cs low until the timer runs out
		stFirstNop,
		stPrechargeInit,	// precharge all banks once
		stNopAfterPrecharge,	// also loads the refresh loop counter
		stRefresh,		// init refresh loop
		stRefreshNop1,
		stRefreshNop2,
		stRefreshNop3,		// loop back or go on to the mode register
		stModeSet,
		stModeNop1,
		stModeNop2,
		stModeNop3,
		stLoadRefreshTimer,	// start the refresh interval
		stIdle,			// wait for refresh due
		stPrechargePeriodic,
		stNopPeriodic,
		stRefreshPeriodic,
		stPeriodicNop1,
		stPeriodicNop2,
		stPeriodicNop3
	} ctrlStateT;

	//////////////////////////////////////////////////////////////////////
	// timing defaults, 50 MHz clock
	//////////////////////////////////////////////////////////////////////

	localparam int timerW = 16;	// both delay timers

	localparam int defPowerUpCycles         = 5000;	// 100 us
	localparam int defRefreshIntervalCycles = 375;	// 7.5 us, 8192 rows in 64 ms
	localparam int defInitRefreshCount      = 10;	// refreshes before mode set

endpackage

//--- design/delayTimer.sv
`timescale 1ns/10ps

module delayTimer #(
	parameter int unsigned LoadValue = 1	// count loaded on a load pulse
) (
	input  logic Clock,
	input  logic Reset_L,
	input  logic load,	// one-cycle pulse, restarts the delay
	output logic done	// high while the count sits at zero
);

	import sdramCtrlPkg::*;

	logic [timerW-1:0] count;	// remaining cycles

	//////////////////////////////////////////////////////////////////////
	// down counter, stops at zero
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			count <= '0;	// idle timer reads as done
		end else if (load) begin
			count <= timerW'(LoadValue);
		end else if (count != '0) begin
			count <= count - 1'b1;	// hold once it hits zero
		end
	end

	assign done = (count == '0);

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// the load value arrives whole on the next edge
	loadTakesEffect: assert property (
		@(posedge Clock) disable iff (!Reset_L)
		load |=> (count == timerW'(LoadValue))
	) else $error("delayTimer: count not at LoadValue after load");

endmodule

//--- design/sdramSequencer.sv
`timescale 1ns/10ps

module sdramSequencer #(
	parameter int InitRefreshCount = sdramCtrlPkg::defInitRefreshCount
) (
	input  logic Clock,
	input  logic Reset_L,

	// timers
	input  logic powerUpDone,	// power-up delay elapsed
	input  logic refreshDue,	// refresh interval elapsed
	output logic powerUpLoad,	// pulse in stInit
	output logic refreshLoad,	// pulse in stLoadRefreshTimer

	// sdram pins, all registered
	output logic sdramCke,
	output logic sdramCs_L,
	output logic sdramRas_L,
	output logic sdramCas_L,
	output logic sdramWe_L,
	output logic [sdramDevicePkg::sdramAddrW-1:0] sdramAddr,
	output logic [sdramDevicePkg::sdramBankW-1:0] sdramBa
);

	import sdramDevicePkg::*;
	import sdramCtrlPkg::*;

	ctrlStateT state;	// current state
	ctrlStateT stateNext;

	logic [3:0] refreshLeft;	// init refreshes still to issue

	sdramCmdT cmdNext;	// command for the pins at the next edge
	logic [sdramAddrW-1:0] addrNext;
	logic [sdramBankW-1:0] baNext;

	sdramCmdT pinCmd;	// pins read back as a command word

	//////////////////////////////////////////////////////////////////////
	// state register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= stInit;
		end else begin
			state <= stateNext;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// init refresh loop counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			refreshLeft <= '0;
		end else if (state == stNopAfterPrecharge) begin
			refreshLeft <= 4'(InitRefreshCount);	// arm before the first refresh
		end else if (state == stRefresh && refreshLeft != '0) begin
			refreshLeft <= refreshLeft - 1'b1;	// one per refresh issued
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		stateNext = stInit;	// unused encodings restart the sequence
		unique case (state)
			stInit:              stateNext = stPowerWait;
			stPowerWait:         stateNext = powerUpDone ? stFirstNop : stPowerWait;
			stFirstNop:          stateNext = stPrechargeInit;
			stPrechargeInit:     stateNext = stNopAfterPrecharge;
			stNopAfterPrecharge: stateNext = stRefresh;
			stRefresh:           stateNext = stRefreshNop1;
			stRefreshNop1:       stateNext = stRefreshNop2;
			stRefreshNop2:       stateNext = stRefreshNop3;
			stRefreshNop3:       stateNext = (refreshLeft == '0) ? stModeSet : stRefresh;
			stModeSet:           stateNext = stModeNop1;
			stModeNop1:          stateNext = stModeNop2;
			stModeNop2:          stateNext = stModeNop3;
			stModeNop3:          stateNext = stLoadRefreshTimer;
			stLoadRefreshTimer:  stateNext = stIdle;
			stIdle:              stateNext = refreshDue ? stPrechargePeriodic : stIdle;
			stPrechargePeriodic: stateNext = stNopPeriodic;
			stNopPeriodic:       stateNext = stRefreshPeriodic;
			stRefreshPeriodic:   stateNext = stPeriodicNop1;
			stPeriodicNop1:      stateNext = stPeriodicNop2;
			stPeriodicNop2:      stateNext = stPeriodicNop3;
			stPeriodicNop3:      stateNext = stLoadRefreshTimer;	// back to waiting
			default:             stateNext = stInit;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// command, address and bank per state
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		cmdNext  = cmdNop;	// most states just idle the bus
		addrNext = '0;
		baNext   = '0;
		unique case (state)
			stInit, stPowerWait: begin
				cmdNext = cmdPowerUp;	// cke and cs held low
			end
			stPrechargeInit, stPrechargePeriodic: begin
				cmdNext          = cmdPrechargeAll;
				addrNext[a10Bit] = 1'b1;	// all banks
			end
			stRefresh, stRefreshPeriodic: begin
				cmdNext = cmdAutoRefresh;
			end
			stModeSet: begin
				cmdNext  = cmdModeRegSet;
				addrNext = modeRegWord;	// burst 1, CAS latency 2
				baNext   = modeRegBank;
			end
			default: begin
				cmdNext = cmdNop;
			end
		endcase
	end

	// timer loads are one cycle wide since both states last one cycle
	assign powerUpLoad = (state == stInit);
	assign refreshLoad = (state == stLoadRefreshTimer);

	//////////////////////////////////////////////////////////////////////
	// pin register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			{sdramCke, sdramCs_L, sdramRas_L, sdramCas_L, sdramWe_L} <= cmdPowerUp;
			sdramAddr <= '0;
			sdramBa   <= '0;
		end else begin
			{sdramCke, sdramCs_L, sdramRas_L, sdramCas_L, sdramWe_L} <= cmdNext;
			sdramAddr <= addrNext;
			sdramBa   <= baNext;
		end
	end

	assign pinCmd = sdramCmdT'({sdramCke, sdramCs_L, sdramRas_L, sdramCas_L, sdramWe_L});

	//////////////////////////////////////////////////////////////////////
	// checks on the pin stream
	//////////////////////////////////////////////////////////////////////

	// tRC, three idle clocks behind every refresh
	refreshThenThreeNops: assert property (
		@(posedge Clock) disable iff (!Reset_L)
		(pinCmd == cmdAutoRefresh) |=> (pinCmd == cmdNop) [*3]
	) else $error("sdramSequencer: auto refresh not followed by three NOPs");

	prechargeAllHasA10: assert property (
		@(posedge Clock) disable iff (!Reset_L)
		(pinCmd == cmdPrechargeAll) |-> sdramAddr[a10Bit]
	) else $error("sdramSequencer: precharge without A10 high");

	// once the device is clocked it stays clocked until the next reset
	noPowerUpAfterStart: assert property (
		@(posedge Clock) disable iff (!Reset_L)
		(pinCmd != cmdPowerUp) |=> (pinCmd != cmdPowerUp)
	) else $error("sdramSequencer: power-up command after first NOP");

endmodule

//--- design/sdramInitRefreshTop.sv
`timescale 1ns/10ps

module sdramInitRefreshTop #(
	parameter int PowerUpCycles         = sdramCtrlPkg::defPowerUpCycles,
	parameter int RefreshIntervalCycles = sdramCtrlPkg::defRefreshIntervalCycles,
	parameter int InitRefreshCount      = sdramCtrlPkg::defInitRefreshCount
) (
	input  logic Clock,
	input  logic Reset_L,	// async, restarts the whole init sequence

	// sdram command pins
	output logic sdramCke,
	output logic sdramCs_L,
	output logic sdramRas_L,
	output logic sdramCas_L,
	output logic sdramWe_L,
	output logic [sdramDevicePkg::sdramAddrW-1:0] sdramAddr,
	output logic [sdramDevicePkg::sdramBankW-1:0] sdramBa
);

	logic powerUpLoad;	// sequencer starts the power-up delay
	logic powerUpDone;
	logic refreshLoad;	// sequencer starts a refresh interval
	logic refreshDue;

	//////////////////////////////////////////////////////////////////////
	// timers
	//////////////////////////////////////////////////////////////////////

	// 100 us hold after power is applied
	delayTimer #(
		.LoadValue (PowerUpCycles)
	) powerUpTimer (
		.Clock   (Clock),
		.Reset_L (Reset_L),
		.load    (powerUpLoad),
		.done    (powerUpDone)
	);

	// spacing between periodic refreshes
	delayTimer #(
		.LoadValue (RefreshIntervalCycles)
	) refreshTimer (
		.Clock   (Clock),
		.Reset_L (Reset_L),
		.load    (refreshLoad),
		.done    (refreshDue)
	);

	//////////////////////////////////////////////////////////////////////
	// init and refresh state machine
	//////////////////////////////////////////////////////////////////////

	sdramSequencer #(
		.InitRefreshCount (InitRefreshCount)
	) sequencer (
		.Clock       (Clock),
		.Reset_L     (Reset_L),
		.powerUpDone (powerUpDone),
		.refreshDue  (refreshDue),
		.powerUpLoad (powerUpLoad),
		.refreshLoad (refreshLoad),
		.sdramCke    (sdramCke),
		.sdramCs_L   (sdramCs_L),
		.sdramRas_L  (sdramRas_L),
		.sdramCas_L  (sdramCas_L),
		.sdramWe_L   (sdramWe_L),
		.sdramAddr   (sdramAddr),
		.sdramBa     (sdramBa)
	);

endmodule

//--- sim/sdramInitRefreshTb.sv
`timescale 1ns/10ps

module sdramInitRefreshTb;

	import sdramDevicePkg::*;

	localparam int clockPeriod    = 40;	// 25 MHz bench clock
	localparam int driveDelay     = 2;	// inputs move this long after the rising edge
	localparam int watchdogCycles = 4000;	// whole run, far above the stim length
	localparam int timeoutSlack   = 4;	// extra clocks allowed past each expected gap

	localparam int tbPowerUpCycles         = 8;
	localparam int tbRefreshIntervalCycles = 8;
	localparam int tbInitRefreshCount      = 4;

	localparam string stimPath = "sim/sdramStim.txt";

	logic Clock;
	logic Reset_L;

	logic sdramCke;
	logic sdramCs_L;
	logic sdramRas_L;
	logic sdramCas_L;
	logic sdramWe_L;
	logic [sdramAddrW-1:0] sdramAddr;
	logic [sdramBankW-1:0] sdramBa;

	logic [4:0] pinWord;	// cke cs ras cas we, as in the stim file

	int sinceLast;	// clocks since the previous command
	int fd;	// stim file handle
	int code;	// scanf return
	int lineNo;
	int resetCycles;
	int gap;
	logic [7:0] kind;	// first character of a stim line
	logic [4:0] stimCmd;
	logic [sdramAddrW-1:0] stimAddr;
	logic [sdramBankW-1:0] stimBank;
	logic [8*200-1:0] restOfLine;	// comment text, thrown away
	string lineName;

	assign pinWord = {sdramCke, sdramCs_L, sdramRas_L, sdramCas_L, sdramWe_L};

	//////////////////////////////////////////////////////////////////////
	// DUT
	//////////////////////////////////////////////////////////////////////

	sdramInitRefreshTop #(
		.PowerUpCycles         (tbPowerUpCycles),
		.RefreshIntervalCycles (tbRefreshIntervalCycles),
		.InitRefreshCount      (tbInitRefreshCount)
	) uut (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.sdramCke   (sdramCke),
		.sdramCs_L  (sdramCs_L),
		.sdramRas_L (sdramRas_L),
		.sdramCas_L (sdramCas_L),
		.sdramWe_L  (sdramWe_L),
		.sdramAddr  (sdramAddr),
		.sdramBa    (sdramBa)
	);

	initial begin
		Clock = 1'b0;
		forever #(clockPeriod / 2) Clock = ~Clock;
	end

	//////////////////////////////////////////////////////////////////////
	// failure handling and checks
	//////////////////////////////////////////////////////////////////////

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			abortRun($sformatf("FAIL %s expected %0h actual %0h", testName, expected, actual));
		end
	endtask

	// command word, address and bank all at once
	task automatic checkPins(input string testName, input logic [4:0] cmd,
			input logic [sdramAddrW-1:0] addr, input logic [sdramBankW-1:0] bank);
		checkValue({testName, " command"}, 32'(cmd), 32'(pinWord));
		checkValue({testName, " address"}, 32'(addr), 32'(sdramAddr));
		checkValue({testName, " bank"}, 32'(bank), 32'(sdramBa));
	endtask

	// pins settle on the rising edge, look at them half a period later
	task automatic nextSample;
		@(posedge Clock);
		@(negedge Clock);
	endtask

	//////////////////////////////////////////////////////////////////////
	// reset, checked while held and in the first cycle after
	//////////////////////////////////////////////////////////////////////

	task automatic applyReset(input int cycles, input string testName);
		int i;
		@(posedge Clock);
		#(driveDelay);
		Reset_L = 1'b0;
		#1;
		checkPins({testName, " on assert"}, cmdPowerUp, '0, '0);	// async, no edge needed
		for (i = 0; i < cycles; i++) begin
			@(posedge Clock);
			#(driveDelay);
			checkPins({testName, " while held"}, cmdPowerUp, '0, '0);
		end
		Reset_L = 1'b1;	// released just after the last held edge
		nextSample;
		checkPins({testName, " first cycle after"}, cmdPowerUp, '0, '0);
		sinceLast = 0;	// gaps after reset count from here
	endtask

	//////////////////////////////////////////////////////////////////////
	// wait for the next command and check it
	//////////////////////////////////////////////////////////////////////

	task automatic expectCommand(input string testName, input logic [4:0] cmd,
			input logic [sdramAddrW-1:0] addr, input logic [sdramBankW-1:0] bank,
			input int expGap);
		logic [4:0] filler;	// what the pins show while waiting
		logic found;
		int waited;
		filler = (cmd == cmdNop) ? cmdPowerUp : cmdNop;	// first NOP follows power-up hold
		found  = 1'b0;
		waited = 0;
		while (!found && waited < expGap + timeoutSlack) begin
			nextSample;
			waited++;
			sinceLast++;
			if (pinWord == cmd) begin
				found = 1'b1;
			end else begin
				checkPins({testName, " idle"}, filler, '0, '0);
			end
		end
		if (!found) begin
			abortRun($sformatf("timeout: %s never showed command %b within %0d clocks",
				testName, cmd, expGap + timeoutSlack));
		end
		checkValue({testName, " gap"}, 32'(expGap), 32'(sinceLast));
		checkPins(testName, cmd, addr, bank);
		sinceLast = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence, driven from the stim file
	//////////////////////////////////////////////////////////////////////

	initial begin
		Reset_L   = 1'b0;	// held from time zero, first edge resets everything
		sinceLast = 0;
		lineNo    = 0;
		fd = $fopen(stimPath, "r");
		if (fd == 0) begin
			abortRun({"could not open the stimulus file ", stimPath});
		end
		code = $fscanf(fd, " %c", kind);
		while (code == 1) begin
			lineNo++;
			lineName = $sformatf("stim line %0d", lineNo);
			if (kind == "#") begin
				code = $fgets(restOfLine, fd);	// comment line
			end else if (kind == "R") begin
				code = $fscanf(fd, " %d", resetCycles);
				if (code != 1) begin
					abortRun({lineName, " has no reset length"});
				end
				applyReset(resetCycles, lineName);
			end else if (kind == "E") begin
				code = $fscanf(fd, " %b %h %h %d", stimCmd, stimAddr, stimBank, gap);
				if (code != 4) begin
					abortRun({lineName, " is not a complete expect line"});
				end
				expectCommand(lineName, stimCmd, stimAddr, stimBank, gap);
			end else begin
				abortRun($sformatf("%s starts with an unknown record type %c", lineName, kind));
			end
			code = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);
		$display("RESULT: PASS");
		$finish;
	end

	// last line of defence if a wait above ever slips past its own limit
	initial begin
		repeat (watchdogCycles) @(posedge Clock);
		abortRun("the run took longer than the overall clock limit");
	end

endmodule

//--- sim/sdramStim.txt
# R cycles              hold Reset_L low for that many clocks
# E cmd addr bank gap   cmd = cke cs ras cas we (binary), addr and bank (hex)
#                       gap = clocks since the previous command, or since reset release
R 5
E 10111 000 0 10
E 10010 400 0 1
E 10001 000 0 2
E 10001 000 0 4
E 10001 000 0 4
E 10001 000 0 4
E 10000 220 0 4
E 10010 400 0 14
E 10001 000 0 2
E 10010 400 0 14
E 10001 000 0 2
E 10010 400 0 14
E 10001 000 0 2
E 10010 400 0 14
R 3
E 10111 000 0 10
E 10010 400 0 1
E 10001 000 0 2
E 10001 000 0 4
E 10001 000 0 4
E 10001 000 0 4
E 10000 220 0 4
E 10010 400 0 14
E 10001 000 0 2

//--- sim.f
design/sdramDevicePkg.sv
design/sdramCtrlPkg.sv
design/delayTimer.sv
design/sdramSequencer.sv
design/sdramInitRefreshTop.sv
sim/sdramInitRefreshTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module sdramInitRefreshTb -Mdir obj_dir -f sim.f &&
./obj_dir/VsdramInitRefreshTb || {
	echo "simulation did not complete cleanly"
	exit 1
}
